//--- hw/axi_burst_macros.svh
`ifndef AXI_BURST_MACROS_SVH
`define AXI_BURST_MACROS_SVH

// bus widths
`define AXI_ADDR_W 64
`define AXI_DATA_W 64
`define AXI_LEN_W 8
`define STRB_W (`AXI_DATA_W / 8)

// one cache line is 8 beats of 64 bits
`define BURST_BEATS 8
`define BEAT_IDX_W 3

// uncached region, single beats only
`define MMIO_BASE 64'h0000_0000_8300_0000

`define RESP_W 2
`define RESP_OKAY 2'b00

`endif

//--- hw/axi_burst_pkg.sv
`include "axi_burst_macros.svh"

package axi_burst_pkg;

  // same request address seen as a byte address or as line/word/byte
  typedef union packed {
    logic [`AXI_ADDR_W-1:0] raw;
    struct packed {
      logic [`AXI_ADDR_W-`BEAT_IDX_W-4:0] line_num;
      logic [`BEAT_IDX_W-1:0]             word;
      logic [2:0]                         ofs;   // byte within 64-bit word
    } line;
  } req_addr_u;

endpackage

//--- hw/xfer_if.sv
`include "axi_burst_macros.svh"

interface xfer_if;

  logic                   grant;
  logic                   pending;
  logic                   owner;     // 0 data port, 1 fetch port
  logic                   is_write;
  logic                   is_mmio;
  logic [`AXI_LEN_W-1:0]  xfer_len;
  logic                   beat_clr;
  logic                   beat_inc;
  logic [`BEAT_IDX_W-1:0] beat_idx;
  logic                   last_beat;

  modport arb (
    input  grant, beat_clr,
    output pending, owner, is_write, is_mmio, xfer_len
  );

  modport fsm (
    input  pending, owner, is_write, last_beat,
    output grant, beat_clr, beat_inc
  );

  modport cnt (
    input  pending, xfer_len, beat_clr, beat_inc,
    output beat_idx, last_beat
  );

  modport rpath (input beat_idx, last_beat, owner);

  modport wpath (input beat_idx, last_beat, is_mmio);

endinterface

//--- hw/req_arbiter.sv
`include "axi_burst_macros.svh"

module req_arbiter (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      d_req_i,
  input  logic                      d_rw_i,
  input  axi_burst_pkg::req_addr_u  d_addr_i,
  input  logic [`AXI_DATA_W-1:0]    d_wdata_i,
  input  logic                      i_req_i,
  input  axi_burst_pkg::req_addr_u  i_addr_i,
  xfer_if.arb                       xfer,
  output logic [`AXI_ADDR_W-1:0]    addr_o,
  output logic [`AXI_DATA_W-1:0]    mmio_wdata_o
);

  localparam int unsigned LINE_LEN = `BURST_BEATS - 1;

  axi_burst_pkg::req_addr_u addr_q;
  axi_burst_pkg::req_addr_u aligned;
  logic [`AXI_DATA_W-1:0]   wdata_q;
  logic                     take;
  logic                     d_mmio;
  logic                     pending_q;
  logic                     owner_q;
  logic                     is_write_q;
  logic                     is_mmio_q;

  assign take   = xfer.grant && (d_req_i || i_req_i);
  assign d_mmio = d_addr_i.raw >= `MMIO_BASE;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pending_q  <= 1'b0;
      owner_q    <= 1'b0;
      is_write_q <= 1'b0;
      is_mmio_q  <= 1'b0;
    end else if (xfer.beat_clr) begin
      pending_q <= 1'b0;   // transfer finished
    end else if (take) begin
      pending_q  <= 1'b1;
      owner_q    <= !d_req_i;   // data port wins a tie
      is_write_q <= d_req_i && d_rw_i;
      is_mmio_q  <= d_req_i && d_mmio;   // fetch is always a line fill
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      addr_q  <= d_req_i ? d_addr_i : i_addr_i;
      wdata_q <= d_wdata_i;
    end
  end

  // burst start is the line base
  always_comb begin
    aligned           = addr_q;
    aligned.line.word = '0;
    aligned.line.ofs  = '0;
  end

  assign addr_o        = is_mmio_q ? addr_q.raw : aligned.raw;
  assign mmio_wdata_o  = wdata_q;
  assign xfer.pending  = pending_q;
  assign xfer.owner    = owner_q;
  assign xfer.is_write = is_write_q;
  assign xfer.is_mmio  = is_mmio_q;
  assign xfer.xfer_len = is_mmio_q ? '0 : LINE_LEN[`AXI_LEN_W-1:0];

  // the FSM must not re-grant while a transfer is still latched
  a_no_grant_while_pending: assert property (
    @(posedge clk) disable iff (rst_i) xfer.grant |-> !pending_q
  );

endmodule

//--- hw/axi_burst_fsm.sv
`include "axi_burst_macros.svh"

module axi_burst_fsm (
  input  logic              clk,
  input  logic              rst_i,
  xfer_if.fsm               xfer,
  input  logic              ar_ready_i,
  input  logic              aw_ready_i,
  input  logic              w_ready_i,
  input  logic [`RESP_W-1:0] r_resp_i,
  input  logic [`RESP_W-1:0] b_resp_i,
  input  logic              r_valid_i,
  input  logic              b_valid_i,
  output logic              ar_valid_o,
  output logic              aw_valid_o,
  output logic              w_valid_o,
  output logic              r_ready_o,
  output logic              b_ready_o,
  output logic              d_done_o,
  output logic              i_done_o,
  output logic              err_o,
  output logic              busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    ADDR_R,
    DATA_R,
    ADDR_W,
    DATA_W,
    RESP_W,
    DONE
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   err_q;
  logic   start;
  logic   bad_resp;

  // latched transfer shows up the cycle after grant
  assign start = (state_q == IDLE) && xfer.pending;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (xfer.pending) begin
          if (xfer.is_write) begin
            state_d = aw_ready_i ? DATA_W : ADDR_W;
          end else begin
            state_d = ar_ready_i ? DATA_R : ADDR_R;
          end
        end
      end
      ADDR_R: if (ar_ready_i) state_d = DATA_R;
      DATA_R: if (r_valid_i && xfer.last_beat) state_d = DONE;
      ADDR_W: if (aw_ready_i) state_d = DATA_W;
      DATA_W: if (w_ready_i && xfer.last_beat) state_d = RESP_W;
      RESP_W: if (b_valid_i) state_d = DONE;
      DONE:   state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign bad_resp = (r_ready_o && r_valid_i && (r_resp_i != `RESP_OKAY)) ||
                    (b_ready_o && b_valid_i && (b_resp_i != `RESP_OKAY));

  // sticky over the whole transfer
  always_ff @(posedge clk) begin
    if (rst_i || state_q == IDLE) begin
      err_q <= 1'b0;
    end else if (bad_resp) begin
      err_q <= 1'b1;
    end
  end

  assign ar_valid_o = (state_q == ADDR_R) || (start && !xfer.is_write);
  assign aw_valid_o = (state_q == ADDR_W) || (start && xfer.is_write);
  assign w_valid_o  = state_q == DATA_W;
  assign r_ready_o  = state_q == DATA_R;
  assign b_ready_o  = state_q == RESP_W;

  assign xfer.grant    = (state_q == IDLE) && !xfer.pending;
  assign xfer.beat_inc = (r_ready_o && r_valid_i) || (w_valid_o && w_ready_i);
  assign xfer.beat_clr = state_q == DONE;   // also releases the arbiter

  assign d_done_o = (state_q == DONE) && !xfer.owner;
  assign i_done_o = (state_q == DONE) && xfer.owner;
  assign err_o    = (state_q == DONE) && err_q;
  assign busy_o   = xfer.pending || (state_q != IDLE);

  // write beats only for a latched write transfer
  a_wvalid_in_data_w: assert property (
    @(posedge clk) disable iff (rst_i)
    w_valid_o |-> xfer.pending && xfer.is_write
  );

endmodule

//--- hw/beat_counter.sv
`include "axi_burst_macros.svh"

module beat_counter (
  input  logic clk,
  input  logic rst_i,
  xfer_if.cnt  xfer
);

  logic [`BEAT_IDX_W-1:0] beat_q;
  logic [`AXI_LEN_W-1:0]  beat_ext;

  assign beat_ext = {{(`AXI_LEN_W - `BEAT_IDX_W){1'b0}}, beat_q};

  always_ff @(posedge clk) begin
    if (rst_i || xfer.beat_clr) begin
      beat_q <= '0;
    end else if (xfer.beat_inc && !xfer.last_beat) begin
      beat_q <= beat_q + 1'b1;   // holds on the final beat
    end
  end

  assign xfer.beat_idx  = beat_q;
  assign xfer.last_beat = beat_ext == xfer.xfer_len;

  // no beat after the final one of a transfer
  a_no_beat_past_len: assert property (
    @(posedge clk) disable iff (rst_i)
    xfer.beat_inc |-> xfer.pending && !$past(xfer.beat_inc && xfer.last_beat)
  );

endmodule

//--- hw/read_beat_path.sv
`include "axi_burst_macros.svh"

module read_beat_path (
  input  logic                   clk,
  input  logic                   rst_i,
  xfer_if.rpath                  xfer,
  input  logic                   r_valid_i,
  input  logic                   r_ready_i,
  input  logic [`AXI_DATA_W-1:0] r_data_i,
  input  logic                   r_last_i,
  output logic                   fill_wen_o,
  output logic [`BEAT_IDX_W-1:0] fill_idx_o,
  output logic                   fill_owner_o,
  output logic [`AXI_DATA_W-1:0] fill_data_o
);

  logic accept;

  assign accept = r_valid_i && r_ready_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fill_wen_o <= 1'b0;
    end else begin
      fill_wen_o <= accept;   // one pulse per accepted beat
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      fill_idx_o   <= xfer.beat_idx;
      fill_owner_o <= xfer.owner;
      fill_data_o  <= r_data_i;
    end
  end

  // slave's last flag must agree with our own beat count
  a_rlast_matches: assert property (
    @(posedge clk) disable iff (rst_i) accept |-> (r_last_i == xfer.last_beat)
  );

endmodule

//--- hw/write_beat_path.sv
`include "axi_burst_macros.svh"

module write_beat_path (
  xfer_if.wpath                  xfer,
  input  logic [`AXI_DATA_W-1:0] line_data_i,
  input  logic [`AXI_DATA_W-1:0] mmio_data_i,
  output logic [`AXI_DATA_W-1:0] w_data_o,
  output logic [`STRB_W-1:0]     w_strb_o,
  output logic                   w_last_o,
  output logic [`BEAT_IDX_W-1:0] line_idx_o
);

  // requester answers line_idx_o combinationally on line_data_i
  assign line_idx_o = xfer.beat_idx;

  assign w_data_o = xfer.is_mmio ? mmio_data_i : line_data_i;
  assign w_strb_o = '1;   // full words only
  assign w_last_o = xfer.last_beat;

endmodule

//--- hw/axi_burst_top.sv
`include "axi_burst_macros.svh"

module axi_burst_top (
  input  logic                   clk,
  input  logic                   rst_i,
  // data port
  input  logic                   d_req_i,
  input  logic                   d_rw_i,
  input  logic [`AXI_ADDR_W-1:0] d_addr_i,
  input  logic [`AXI_DATA_W-1:0] d_wdata_i,
  output logic                   d_done_o,
  // fetch port
  input  logic                   i_req_i,
  input  logic [`AXI_ADDR_W-1:0] i_addr_i,
  output logic                   i_done_o,
  // status and fill bus
  output logic                   err_o,
  output logic                   busy_o,
  output logic                   fill_wen_o,
  output logic [`BEAT_IDX_W-1:0] fill_idx_o,
  output logic                   fill_owner_o,
  output logic [`AXI_DATA_W-1:0] fill_data_o,
  // writeback line words
  output logic [`BEAT_IDX_W-1:0] line_idx_o,
  input  logic [`AXI_DATA_W-1:0] line_data_i,
  // AXI
  input  logic                   aw_ready_i,
  output logic                   aw_valid_o,
  output logic [`AXI_ADDR_W-1:0] aw_addr_o,
  output logic [`AXI_LEN_W-1:0]  aw_len_o,
  input  logic                   w_ready_i,
  output logic                   w_valid_o,
  output logic [`AXI_DATA_W-1:0] w_data_o,
  output logic [`STRB_W-1:0]     w_strb_o,
  output logic                   w_last_o,
  output logic                   b_ready_o,
  input  logic                   b_valid_i,
  input  logic [`RESP_W-1:0]     b_resp_i,
  input  logic                   ar_ready_i,
  output logic                   ar_valid_o,
  output logic [`AXI_ADDR_W-1:0] ar_addr_o,
  output logic [`AXI_LEN_W-1:0]  ar_len_o,
  output logic                   r_ready_o,
  input  logic                   r_valid_i,
  input  logic [`RESP_W-1:0]     r_resp_i,
  input  logic [`AXI_DATA_W-1:0] r_data_i,
  input  logic                   r_last_i
);

  logic [`AXI_ADDR_W-1:0] req_addr;
  logic [`AXI_DATA_W-1:0] mmio_wdata;

  xfer_if xfer ();

  req_arbiter arb0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .d_req_i     (d_req_i),
    .d_rw_i      (d_rw_i),
    .d_addr_i    (d_addr_i),
    .d_wdata_i   (d_wdata_i),
    .i_req_i     (i_req_i),
    .i_addr_i    (i_addr_i),
    .xfer        (xfer.arb),
    .addr_o      (req_addr),
    .mmio_wdata_o(mmio_wdata)
  );

  axi_burst_fsm fsm0 (
    .clk       (clk),
    .rst_i     (rst_i),
    .xfer      (xfer.fsm),
    .ar_ready_i(ar_ready_i),
    .aw_ready_i(aw_ready_i),
    .w_ready_i (w_ready_i),
    .r_resp_i  (r_resp_i),
    .b_resp_i  (b_resp_i),
    .r_valid_i (r_valid_i),
    .b_valid_i (b_valid_i),
    .ar_valid_o(ar_valid_o),
    .aw_valid_o(aw_valid_o),
    .w_valid_o (w_valid_o),
    .r_ready_o (r_ready_o),
    .b_ready_o (b_ready_o),
    .d_done_o  (d_done_o),
    .i_done_o  (i_done_o),
    .err_o     (err_o),
    .busy_o    (busy_o)
  );

  beat_counter cnt0 (
    .clk  (clk),
    .rst_i(rst_i),
    .xfer (xfer.cnt)
  );

  read_beat_path rd0 (
    .clk         (clk),
    .rst_i       (rst_i),
    .xfer        (xfer.rpath),
    .r_valid_i   (r_valid_i),
    .r_ready_i   (r_ready_o),
    .r_data_i    (r_data_i),
    .r_last_i    (r_last_i),
    .fill_wen_o  (fill_wen_o),
    .fill_idx_o  (fill_idx_o),
    .fill_owner_o(fill_owner_o),
    .fill_data_o (fill_data_o)
  );

  write_beat_path wr0 (
    .xfer       (xfer.wpath),
    .line_data_i(line_data_i),
    .mmio_data_i(mmio_wdata),
    .w_data_o   (w_data_o),
    .w_strb_o   (w_strb_o),
    .w_last_o   (w_last_o),
    .line_idx_o (line_idx_o)
  );

  // both address channels carry the latched request
  assign ar_addr_o = req_addr;
  assign aw_addr_o = req_addr;
  assign ar_len_o  = xfer.xfer_len;
  assign aw_len_o  = xfer.xfer_len;

endmodule

//--- verif/tb_axi_burst.sv
`include "axi_burst_macros.svh"

module tb_axi_burst;

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int SEED            = 87132;
  localparam logic [63:0] LINE_AREA = 64'h0000_0000_0001_0000;
  localparam logic [63:0] MMIO_ADDR = `MMIO_BASE + 64'h123;   // deliberately unaligned

  logic clk;
  logic rst_i = 1'b1;
  logic d_req_i = 1'b0, d_rw_i = 1'b0, i_req_i = 1'b0;
  logic [63:0] d_addr_i = '0, d_wdata_i = '0, i_addr_i = '0;
  logic d_done_o, i_done_o, err_o, busy_o, fill_wen_o, fill_owner_o;
  logic [2:0] fill_idx_o, line_idx_o;
  logic [63:0] fill_data_o, line_data_i;
  logic aw_ready_i = 1'b0, w_ready_i = 1'b0, b_valid_i = 1'b0;
  logic ar_ready_i = 1'b0, r_valid_i = 1'b0, r_last_i = 1'b0;
  logic [1:0] b_resp_i = '0, r_resp_i = '0;
  logic [63:0] r_data_i = '0;
  logic aw_valid_o, w_valid_o, w_last_o, b_ready_o, ar_valid_o, r_ready_o;
  logic [63:0] aw_addr_o, w_data_o, ar_addr_o;
  logic [7:0] aw_len_o, ar_len_o, w_strb_o;

  // slave model state
  logic [63:0] mem [logic [60:0]];   // keyed by word address
  logic [63:0] line_buf [8] = '{default: '0};
  logic [63:0] ar_addr_log[$], aw_addr_log[$], fill_dat_q[$];
  logic [7:0] ar_len_log[$], aw_len_log[$];
  logic [2:0] fill_idx_q[$];
  logic fill_own_q[$];
  int stall_pct = 20;
  int err_beat = -1;   // read beat answered with SLVERR
  bit b_err = 1'b0;
  bit rd_busy, wr_busy, b_pend;
  logic [63:0] rd_addr, wr_addr;
  int rd_len, rd_beat, wr_len, wr_beat;
  int w_last_cnt = 0;

  axi_burst_top dut0 (.*);

  // requester answers the writeback index combinationally
  assign line_data_i = line_buf[line_idx_o];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD);
    report_error("watchdog expired before the tests finished");
  end

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_error(string msg);
    $display("ERROR t=%0t %s", $time, msg);
    abort_run();
  endtask

  task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endtask

  function automatic logic [63:0] mem_read(logic [63:0] addr);
    if (mem.exists(addr[63:3])) return mem[addr[63:3]];
    return {addr[31:0], ~addr[63:32]} ^ 64'h9e37_79b9_7f4a_7c15;   // untouched words
  endfunction

  function automatic bit slave_go();
    return ($urandom % 100) >= stall_pct;
  endfunction

  // read side: ar, then r beats with gaps
  always @(posedge clk) begin
    if (rst_i) begin
      ar_ready_i <= 1'b0;
      r_valid_i  <= 1'b0;
      r_last_i   <= 1'b0;
      rd_busy = 1'b0;
    end else begin
      if (r_valid_i && r_ready_o) begin
        rd_beat++;
        rd_busy = rd_beat <= rd_len;
      end
      if (ar_valid_o && ar_ready_i) begin
        ar_addr_log.push_back(ar_addr_o);
        ar_len_log.push_back(ar_len_o);
        rd_addr = ar_addr_o;
        rd_len  = ar_len_o;
        rd_beat = 0;
        rd_busy = 1'b1;
      end
      ar_ready_i <= !rd_busy && slave_go();
      if (!r_valid_i || r_ready_o) begin   // a shown beat holds until taken
        if (rd_busy && slave_go()) begin
          r_valid_i <= 1'b1;
          r_data_i  <= mem_read(rd_addr + 64'(rd_beat * 8));
          r_last_i  <= rd_beat == rd_len;
          r_resp_i  <= (rd_beat == err_beat) ? 2'b10 : 2'b00;
        end else begin
          r_valid_i <= 1'b0;
        end
      end
    end
  end

  // write side: aw, w beats into memory, then b
  always @(posedge clk) begin
    if (rst_i) begin
      aw_ready_i <= 1'b0;
      w_ready_i  <= 1'b0;
      b_valid_i  <= 1'b0;
      wr_busy = 1'b0;
      b_pend  = 1'b0;
    end else begin
      if (w_valid_o && w_ready_i) begin
        check_eq("w_last_o", w_last_o, wr_beat == wr_len);
        check_eq("w_strb_o", w_strb_o, 8'hff);
        mem[wr_addr[63:3] + wr_beat] = w_data_o;
        w_last_cnt += w_last_o;
        b_pend = wr_beat == wr_len;
        wr_beat++;
      end
      if (b_valid_i && b_ready_o) begin
        b_valid_i <= 1'b0;
        wr_busy = 1'b0;
        b_pend  = 1'b0;
      end else if (b_pend && !b_valid_i && slave_go()) begin
        b_valid_i <= 1'b1;
        b_resp_i  <= b_err ? 2'b10 : 2'b00;
      end
      if (aw_valid_o && aw_ready_i) begin
        aw_addr_log.push_back(aw_addr_o);
        aw_len_log.push_back(aw_len_o);
        wr_addr = aw_addr_o;
        wr_len  = aw_len_o;
        wr_beat = 0;
        wr_busy = 1'b1;
      end
      aw_ready_i <= !wr_busy && slave_go();
      w_ready_i  <= wr_busy && !b_pend && slave_go();
    end
  end

  always @(posedge clk) begin
    if (fill_wen_o) begin
      fill_idx_q.push_back(fill_idx_o);
      fill_own_q.push_back(fill_owner_o);
      fill_dat_q.push_back(fill_data_o);
    end
  end

  task automatic clear_logs();
    ar_addr_log.delete();
    ar_len_log.delete();
    aw_addr_log.delete();
    aw_len_log.delete();
    fill_idx_q.delete();
    fill_own_q.delete();
    fill_dat_q.delete();
  endtask

  task automatic check_quiet();
    check_eq("ar_valid_o", ar_valid_o, 0);
    check_eq("aw_valid_o", aw_valid_o, 0);
    check_eq("w_valid_o", w_valid_o, 0);
    check_eq("r_ready_o", r_ready_o, 0);
    check_eq("b_ready_o", b_ready_o, 0);
    check_eq("d_done_o", d_done_o, 0);
    check_eq("i_done_o", i_done_o, 0);
    check_eq("fill_wen_o", fill_wen_o, 0);
  endtask

  task automatic apply_reset();
    rst_i <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    check_quiet();
    rst_i <= 1'b0;
  endtask

  task automatic wait_done(bit port, output logic err);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      assert (n < CYCLES_PER_TEST) else report_error("no done pulse for the waiting port");
      assert (!(port ? d_done_o : i_done_o)) else report_error("done pulse went to the other port");
      if (n > 1) check_eq("busy_o", busy_o, 1);   // request latched after the first cycle
    end while (port ? !i_done_o : !d_done_o);
    err = err_o;
  endtask

  task automatic data_request(bit rw, logic [63:0] addr, logic [63:0] wdata, output logic err);
    @(posedge clk);
    d_req_i   <= 1'b1;
    d_rw_i    <= rw;
    d_addr_i  <= addr;
    d_wdata_i <= wdata;
    wait_done(1'b0, err);
    d_req_i <= 1'b0;
    @(posedge clk);   // lets the fill monitor catch up
    check_eq("busy_o", busy_o, 0);
  endtask

  task automatic check_line_fill(int first, logic [63:0] addr, bit owner);
    logic [63:0] base;
    base = addr & ~64'h3f;
    for (int i = 0; i < 8; i++) begin
      check_eq("fill_idx_o", fill_idx_q[first + i], i);
      check_eq("fill_owner_o", fill_own_q[first + i], owner);
      check_eq("fill_data_o", fill_dat_q[first + i], mem_read(base + 64'(i * 8)));
    end
  endtask

  task automatic test_data_fill();
    logic err;
    logic [63:0] addr;
    addr = LINE_AREA + 64'h40 + 64'h1d;
    clear_logs();
    data_request(1'b0, addr, '0, err);
    check_eq("ar_addr_o", ar_addr_log[0], addr & ~64'h3f);
    check_eq("ar_len_o", ar_len_log[0], 7);
    check_eq("fill beat count", fill_idx_q.size(), 8);
    check_line_fill(0, addr, 1'b0);
    check_eq("err_o", err, 0);
  endtask

  task automatic test_writeback();
    logic err;
    logic [63:0] addr;
    int lasts;
    addr = LINE_AREA + 64'h80 + 64'h10;
    foreach (line_buf[i]) line_buf[i] = {$urandom, $urandom};
    lasts = w_last_cnt;
    clear_logs();
    data_request(1'b1, addr, '0, err);
    check_eq("aw_addr_o", aw_addr_log[0], addr & ~64'h3f);
    check_eq("aw_len_o", aw_len_log[0], 7);
    check_eq("w_last_o count", w_last_cnt - lasts, 1);
    for (int i = 0; i < 8; i++) begin
      check_eq("memory word", mem_read((addr & ~64'h3f) + 64'(i * 8)), line_buf[i]);
    end
    check_eq("err_o", err, 0);
  endtask

  task automatic test_mmio();
    logic err;
    logic [63:0] wdata;
    clear_logs();
    data_request(1'b0, MMIO_ADDR, '0, err);
    check_eq("ar_addr_o", ar_addr_log[0], MMIO_ADDR);
    check_eq("ar_len_o", ar_len_log[0], 0);
    check_eq("fill beat count", fill_idx_q.size(), 1);
    check_eq("fill_idx_o", fill_idx_q[0], 0);
    check_eq("fill_data_o", fill_dat_q[0], mem_read(MMIO_ADDR));
    check_eq("err_o", err, 0);
    wdata = {$urandom, $urandom};
    data_request(1'b1, MMIO_ADDR, wdata, err);
    check_eq("aw_addr_o", aw_addr_log[0], MMIO_ADDR);
    check_eq("aw_len_o", aw_len_log[0], 0);
    check_eq("mmio word", mem_read(MMIO_ADDR), wdata);
    check_eq("err_o", err, 0);
  endtask

  task automatic test_arbitration();
    logic err;
    logic [63:0] d_addr, i_addr;
    d_addr = LINE_AREA + 64'h100 + 64'h8;
    i_addr = LINE_AREA + 64'h1c0 + 64'h31;
    clear_logs();
    @(posedge clk);
    d_req_i  <= 1'b1;
    d_rw_i   <= 1'b0;
    d_addr_i <= d_addr;
    i_req_i  <= 1'b1;
    i_addr_i <= i_addr;
    wait_done(1'b0, err);   // data port must win the tie
    d_req_i <= 1'b0;
    check_eq("err_o", err, 0);
    wait_done(1'b1, err);
    i_req_i <= 1'b0;
    @(posedge clk);
    check_eq("err_o", err, 0);
    check_eq("ar_addr_o", ar_addr_log[0], d_addr & ~64'h3f);
    check_eq("ar_addr_o", ar_addr_log[1], i_addr & ~64'h3f);
    check_eq("fill beat count", fill_idx_q.size(), 16);
    check_line_fill(0, d_addr, 1'b0);
    check_line_fill(8, i_addr, 1'b1);
  endtask

  task automatic test_stall_and_errors();
    logic err;
    logic [63:0] addr;
    addr = LINE_AREA + 64'hc0 + 64'h2;
    stall_pct = 85;
    clear_logs();
    data_request(1'b0, addr, '0, err);
    check_eq("fill beat count", fill_idx_q.size(), 8);
    check_line_fill(0, addr, 1'b0);
    check_eq("err_o", err, 0);
    stall_pct = 20;
    err_beat  = 5;
    data_request(1'b0, LINE_AREA + 64'h140, '0, err);
    check_eq("err_o on r error", err, 1);
    err_beat = -1;
    b_err    = 1'b1;
    data_request(1'b1, LINE_AREA + 64'h180, '0, err);
    check_eq("err_o on b error", err, 1);
    b_err = 1'b0;
    @(posedge clk);
    apply_reset();
  endtask

  initial begin
    void'($urandom(SEED));
    for (int i = 0; i < 64; i++) begin
      mem[LINE_AREA[63:3] + i] = {$urandom, $urandom};
    end
    mem[MMIO_ADDR[63:3]] = {$urandom, $urandom};
    apply_reset();
    test_data_fill();
    test_writeback();
    test_mmio();
    test_arbitration();
    test_stall_and_errors();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- axi_burst.f
+incdir+hw
hw/axi_burst_pkg.sv
hw/xfer_if.sv
hw/req_arbiter.sv
hw/axi_burst_fsm.sv
hw/beat_counter.sv
hw/read_beat_path.sv
hw/write_beat_path.sv
hw/axi_burst_top.sv
verif/tb_axi_burst.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_axi_burst
FILELIST  := axi_burst.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
